// File: design/cpu_cfg.svh
// CPU width and memory configuration
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath widths
`define DATA_W    8
`define ADDR_W    8
`define INST_W    16

// Memory size in bytes, one per address
`define MEM_DEPTH 256

// First fetch address after reset
`define PC_RESET  8'h00

`endif

// File: design/cpuPkg.sv
// CPU shared types
package cpuPkg;

    // Instruction opcodes, codes 11 and 12 are no-ops
    typedef enum logic [3:0] {
        opBra = 4'd0,
        opLd  = 4'd1,
        opSt  = 4'd2,
        opMov = 4'd3,
        opAnd = 4'd4,
        opOr  = 4'd5,
        opNot = 4'd6,
        opAdd = 4'd7,
        opSub = 4'd8,
        opLsr = 4'd9,
        opLsl = 4'd10,
        opInc = 4'd13,
        opDec = 4'd14,
        opBne = 4'd15
    } opcodeE;

    typedef enum logic [3:0] {
        aluPassA, aluPassB, aluNotA, aluAdd, aluSub,
        aluAnd, aluOr, aluXor, aluShl, aluShr
    } aluOpE;

    typedef enum logic [1:0] {rfDec, rfInc, rfLoad, rfClear} regFunE;

    typedef enum logic [2:0] {fetchHi, fetchLo, addrLoad, execute, waitRun} stateE;

endpackage

// File: design/alu.sv
// Arithmetic and logic unit with flag register
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module alu (
    input  logic                CLK,
    input  logic                rst_i,
    input  cpuPkg::aluOpE       op_i,
    input  logic [`DATA_W-1:0]  a_i,
    input  logic [`DATA_W-1:0]  b_i,
    input  logic                flagsWe_i,
    output logic [`DATA_W-1:0]  result_o,
    output logic [3:0]          flags_o
);

    localparam int MSB = `DATA_W - 1;

    logic [`DATA_W:0] sum;
    logic [`DATA_W:0] diff;
    logic             carry;
    logic             overflow;

    assign sum  = {1'b0, a_i} + {1'b0, b_i};
    assign diff = {1'b0, a_i} - {1'b0, b_i};   // Top bit is the borrow

    always_comb begin
        carry    = 1'b0;
        overflow = 1'b0;
        case (op_i)
            cpuPkg::aluPassA: result_o = a_i;
            cpuPkg::aluPassB: result_o = b_i;
            cpuPkg::aluNotA:  result_o = ~a_i;
            cpuPkg::aluAdd: begin
                result_o = sum[MSB:0];
                carry    = sum[`DATA_W];
                overflow = (a_i[MSB] == b_i[MSB]) && (sum[MSB] != a_i[MSB]);
            end
            cpuPkg::aluSub: begin
                result_o = diff[MSB:0];
                carry    = diff[`DATA_W];
                overflow = (a_i[MSB] != b_i[MSB]) && (diff[MSB] != a_i[MSB]);
            end
            cpuPkg::aluAnd: result_o = a_i & b_i;
            cpuPkg::aluOr:  result_o = a_i | b_i;
            cpuPkg::aluXor: result_o = a_i ^ b_i;
            cpuPkg::aluShl: begin
                result_o = {a_i[MSB-1:0], 1'b0};
                carry    = a_i[MSB];   // Bit shifted out
            end
            cpuPkg::aluShr: begin
                result_o = {1'b0, a_i[MSB:1]};
                carry    = a_i[0];
            end
            default: result_o = a_i;
        endcase
    end

    // Flag order is Z, C, N, O from the top bit down
    always_ff @(posedge CLK) begin
        if (rst_i) begin
            flags_o <= 4'b0000;
        end else if (flagsWe_i) begin
            flags_o <= {(result_o == '0), carry, result_o[MSB], overflow};
        end
    end

endmodule

// File: design/regFile.sv
// Four-entry general register file
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module regFile (
    input  logic                CLK,
    input  logic                rst_i,
    input  logic [3:0]          we_i,
    input  cpuPkg::regFunE      fun_i,
    input  logic [1:0]          selA_i,
    input  logic [1:0]          selB_i,
    input  logic [`DATA_W-1:0]  data_i,
    output logic [`DATA_W-1:0]  outA_o,
    output logic [`DATA_W-1:0]  outB_o
);

    logic [`DATA_W-1:0] regs [4];
    logic [`DATA_W-1:0] nextVal;

    // Functions act on the incoming word, so INC and DEC can take any source
    always_comb begin
        case (fun_i)
            cpuPkg::rfDec:  nextVal = data_i - 1'b1;
            cpuPkg::rfInc:  nextVal = data_i + 1'b1;
            cpuPkg::rfLoad: nextVal = data_i;
            default:        nextVal = '0;   // Clear
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rst_i) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (we_i[i]) begin
                    regs[i] <= nextVal;
                end
            end
        end
    end

    assign outA_o = regs[selA_i];
    assign outB_o = regs[selB_i];

endmodule

// File: design/addressRegs.sv
// Program counter and address register
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module addressRegs (
    input  logic                CLK,
    input  logic                rst_i,
    input  logic                pcInc_i,
    input  logic                pcLoad_i,
    input  logic                arLoad_i,
    input  logic [`ADDR_W-1:0]  target_i,
    output logic [`ADDR_W-1:0]  pc_o,
    output logic [`ADDR_W-1:0]  ar_o
);

    // PC counts through fetch, a taken branch overrides the count
    always_ff @(posedge CLK) begin
        if (rst_i) begin
            pc_o <= `PC_RESET;
        end else if (pcLoad_i) begin
            pc_o <= target_i;
        end else if (pcInc_i) begin
            pc_o <= pc_o + 1'b1;
        end
    end

    // AR holds the direct operand address for LD and ST
    always_ff @(posedge CLK) begin
        if (rst_i) begin
            ar_o <= '0;
        end else if (arLoad_i) begin
            ar_o <= target_i;
        end
    end

endmodule

// File: design/memory.sv
// Byte-wide RAM with program load port
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module memory (
    input  logic                CLK,
    input  logic                we_i,
    input  logic [`ADDR_W-1:0]  addr_i,
    input  logic [`DATA_W-1:0]  data_i,
    input  logic                loadEn_i,
    input  logic [`ADDR_W-1:0]  loadAddr_i,
    input  logic [`DATA_W-1:0]  loadData_i,
    output logic [`DATA_W-1:0]  rdata_o
);

    logic [`DATA_W-1:0] mem [`MEM_DEPTH];

    // Load port wins, the CPU is held waiting meanwhile
    always_ff @(posedge CLK) begin
        if (loadEn_i) begin
            mem[loadAddr_i] <= loadData_i;
        end else if (we_i) begin
            mem[addr_i] <= data_i;
        end
    end

    assign rdata_o = mem[addr_i];   // Asynchronous read

endmodule

// File: design/controlFsm.sv
// Fetch and execute control unit
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module controlFsm (
    input  logic                CLK,
    input  logic                rst_i,
    input  logic                run_i,
    input  logic                loadEn_i,
    input  logic [`DATA_W-1:0]  irHi_i,
    input  logic [`DATA_W-1:0]  irLo_i,
    input  logic                zeroFlag_i,
    output cpuPkg::regFunE      rfFun_o,
    output logic [3:0]          rfWe_o,
    output logic [1:0]          rfSelA_o,
    output logic [1:0]          rfSelB_o,
    output cpuPkg::aluOpE       aluOp_o,
    output logic                flagsWe_o,
    output logic                pcInc_o,
    output logic                pcLoad_o,
    output logic                arLoad_o,
    output logic                addrSel_o,
    output logic                memWe_o,
    output logic                irHiWe_o,
    output logic                irLoWe_o,
    output logic [1:0]          rfSrcSel_o,
    output logic                instDone_o
);

    cpuPkg::stateE  state;
    cpuPkg::stateE  stateNext;
    cpuPkg::opcodeE opcode;
    logic [1:0]     dstReg;
    logic [3:0]     dstWe;
    logic           immMode;
    logic           needAddr;
    logic           startRun;

    assign opcode   = cpuPkg::opcodeE'(irHi_i[7:4]);
    assign dstReg   = irHi_i[1:0];
    assign dstWe    = 4'b0001 << dstReg;   // One-hot destination enable
    assign immMode  = irHi_i[2];            // LD mode, 1 selects immediate
    assign startRun = run_i && !loadEn_i;

    // Direct LD and every ST need AR loaded before execute
    assign needAddr = (opcode == cpuPkg::opSt) || ((opcode == cpuPkg::opLd) && !immMode);

    always_ff @(posedge CLK) begin
        if (rst_i) begin
            state <= cpuPkg::waitRun;
        end else begin
            state <= stateNext;
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            cpuPkg::waitRun: begin
                if (startRun) begin
                    stateNext = cpuPkg::fetchHi;
                end
            end
            cpuPkg::fetchHi:  stateNext = cpuPkg::fetchLo;
            cpuPkg::fetchLo:  stateNext = needAddr ? cpuPkg::addrLoad : cpuPkg::execute;
            cpuPkg::addrLoad: stateNext = cpuPkg::execute;
            cpuPkg::execute:  stateNext = startRun ? cpuPkg::fetchHi : cpuPkg::waitRun;
            default:          stateNext = cpuPkg::waitRun;
        endcase
    end

    // ALU function per opcode, only used in execute
    always_comb begin
        case (opcode)
            cpuPkg::opAnd: aluOp_o = cpuPkg::aluAnd;
            cpuPkg::opOr:  aluOp_o = cpuPkg::aluOr;
            cpuPkg::opNot: aluOp_o = cpuPkg::aluNotA;
            cpuPkg::opAdd: aluOp_o = cpuPkg::aluAdd;
            cpuPkg::opSub: aluOp_o = cpuPkg::aluSub;
            cpuPkg::opLsr: aluOp_o = cpuPkg::aluShr;
            cpuPkg::opLsl: aluOp_o = cpuPkg::aluShl;
            default:       aluOp_o = cpuPkg::aluPassA;   // MOV, INC, DEC
        endcase
    end

    always_comb begin
        rfFun_o    = cpuPkg::rfLoad;
        rfWe_o     = 4'b0000;
        rfSelA_o   = irLo_i[5:4];   // First source field
        rfSelB_o   = irLo_i[1:0];   // Second source field
        flagsWe_o  = 1'b0;
        pcInc_o    = 1'b0;
        pcLoad_o   = 1'b0;
        arLoad_o   = 1'b0;
        addrSel_o  = 1'b0;          // PC drives the memory address
        memWe_o    = 1'b0;
        irHiWe_o   = 1'b0;
        irLoWe_o   = 1'b0;
        rfSrcSel_o = 2'd2;          // 0 immediate, 1 memory, 2 ALU
        instDone_o = 1'b0;
        case (state)
            cpuPkg::fetchHi: begin
                irHiWe_o = 1'b1;
                pcInc_o  = 1'b1;
            end
            cpuPkg::fetchLo: begin
                irLoWe_o = 1'b1;
                pcInc_o  = 1'b1;
            end
            cpuPkg::addrLoad: arLoad_o = 1'b1;
            cpuPkg::execute: begin
                instDone_o = 1'b1;
                case (opcode)
                    cpuPkg::opBra: pcLoad_o = 1'b1;
                    cpuPkg::opBne: pcLoad_o = !zeroFlag_i;   // Taken on nonzero
                    cpuPkg::opLd: begin
                        rfWe_o     = dstWe;
                        addrSel_o  = 1'b1;
                        rfSrcSel_o = immMode ? 2'd0 : 2'd1;
                    end
                    cpuPkg::opSt: begin
                        addrSel_o = 1'b1;
                        memWe_o   = 1'b1;
                        rfSelB_o  = dstReg;   // Store source sits in the high byte
                    end
                    cpuPkg::opMov: rfWe_o = dstWe;
                    cpuPkg::opAnd, cpuPkg::opOr, cpuPkg::opNot, cpuPkg::opAdd,
                    cpuPkg::opSub, cpuPkg::opLsr, cpuPkg::opLsl: begin
                        rfWe_o    = dstWe;
                        flagsWe_o = 1'b1;
                    end
                    cpuPkg::opInc: begin
                        rfWe_o  = dstWe;
                        rfFun_o = cpuPkg::rfInc;   // Source + 1 into destination
                    end
                    cpuPkg::opDec: begin
                        rfWe_o  = dstWe;
                        rfFun_o = cpuPkg::rfDec;
                    end
                    default: rfWe_o = 4'b0000;     // Unused codes do nothing
                endcase
            end
            default: instDone_o = 1'b0;
        endcase
    end

endmodule

// File: design/cpuTop.sv
// Register machine top level
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module cpuTop (
    input  logic                CLK,
    input  logic                rst_i,
    input  logic                loadEn_i,
    input  logic [`ADDR_W-1:0]  loadAddr_i,
    input  logic [`DATA_W-1:0]  loadData_i,
    input  logic                run_i,
    output logic [`ADDR_W-1:0]  pc_o,
    output logic [3:0]          flags_o,
    output logic                memWe_o,
    output logic [`ADDR_W-1:0]  memAddr_o,
    output logic [`DATA_W-1:0]  memData_o,
    output logic                instDone_o
);

    logic [`INST_W-1:0]  ir;
    logic [`DATA_W-1:0]  irHi;
    logic [`DATA_W-1:0]  irLo;
    logic [`DATA_W-1:0]  memRdata;
    logic [`DATA_W-1:0]  rfData;
    logic [`DATA_W-1:0]  rfOutA;
    logic [`DATA_W-1:0]  aluResult;
    logic [`ADDR_W-1:0]  ar;
    cpuPkg::regFunE      rfFun;
    cpuPkg::aluOpE       aluOp;
    logic [3:0]          rfWe;
    logic [1:0]          rfSelA;
    logic [1:0]          rfSelB;
    logic [1:0]          rfSrcSel;
    logic                flagsWe;
    logic                pcInc;
    logic                pcLoad;
    logic                arLoad;
    logic                addrSel;
    logic                irHiWe;
    logic                irLoWe;

    assign irHi = ir[`INST_W-1:`DATA_W];
    assign irLo = ir[`DATA_W-1:0];

    // Instruction register, filled one byte per fetch state
    always_ff @(posedge CLK) begin
        if (rst_i) begin
            ir <= '0;
        end else begin
            if (irHiWe) begin
                ir[`INST_W-1:`DATA_W] <= memRdata;
            end
            if (irLoWe) begin
                ir[`DATA_W-1:0] <= memRdata;
            end
        end
    end

    assign memAddr_o = addrSel ? ar : pc_o;   // AR only for LD and ST execute

    always_comb begin
        case (rfSrcSel)
            2'd0:    rfData = irLo;       // Immediate
            2'd1:    rfData = memRdata;
            default: rfData = aluResult;
        endcase
    end

    controlFsm uFsm (
        .CLK(CLK), .rst_i(rst_i), .run_i(run_i), .loadEn_i(loadEn_i),
        .irHi_i(irHi), .irLo_i(irLo), .zeroFlag_i(flags_o[3]),
        .rfFun_o(rfFun), .rfWe_o(rfWe), .rfSelA_o(rfSelA), .rfSelB_o(rfSelB),
        .aluOp_o(aluOp), .flagsWe_o(flagsWe), .pcInc_o(pcInc), .pcLoad_o(pcLoad),
        .arLoad_o(arLoad), .addrSel_o(addrSel), .memWe_o(memWe_o),
        .irHiWe_o(irHiWe), .irLoWe_o(irLoWe), .rfSrcSel_o(rfSrcSel),
        .instDone_o(instDone_o)
    );

    addressRegs uAddr (
        .CLK(CLK), .rst_i(rst_i), .pcInc_i(pcInc), .pcLoad_i(pcLoad),
        .arLoad_i(arLoad), .target_i(irLo), .pc_o(pc_o), .ar_o(ar)
    );

    regFile uRegs (
        .CLK(CLK), .rst_i(rst_i), .we_i(rfWe), .fun_i(rfFun), .selA_i(rfSelA),
        .selB_i(rfSelB), .data_i(rfData), .outA_o(rfOutA), .outB_o(memData_o)
    );

    alu uAlu (
        .CLK(CLK), .rst_i(rst_i), .op_i(aluOp), .a_i(rfOutA), .b_i(memData_o),
        .flagsWe_i(flagsWe), .result_o(aluResult), .flags_o(flags_o)
    );

    memory uMem (
        .CLK(CLK), .we_i(memWe_o), .addr_i(memAddr_o), .data_i(memData_o),
        .loadEn_i(loadEn_i), .loadAddr_i(loadAddr_i), .loadData_i(loadData_i),
        .rdata_o(memRdata)
    );

endmodule

// File: testbench/clockGen.sv
// Testbench clock and reset
`timescale 1ns/10ps

module clockGen (
    output logic CLK,
    output logic rst_o
);

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;   // 100 ns period
    end

    initial begin
        rst_o = 1'b1;
        repeat (5) @(posedge CLK);
        rst_o <= 1'b0;            // Released after five reset edges
    end

endmodule

// File: testbench/cpu_properties.sv
// CPU top level timing assertions
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module cpuProperties (
    input logic                CLK,
    input logic                rst_i,
    input logic [`ADDR_W-1:0]  pc_i,
    input logic [3:0]          flags_i,
    input logic                memWe_i,
    input logic                instDone_i,
    input logic [`INST_W-1:0]  ir_i
);

    int                 assertFails = 0;
    logic [3:0]         op;
    logic               isBranch;
    logic               seenDone;
    logic               lastBranch;
    logic [`ADDR_W-1:0] lastPc;

    assign op       = ir_i[`INST_W-1:`INST_W-4];
    assign isBranch = (op == 4'd0) || (op == 4'd15);   // BRA or BNE

    // PC seen at the previous instruction end
    always_ff @(posedge CLK) begin
        if (rst_i) begin
            seenDone   <= 1'b0;
            lastBranch <= 1'b0;
            lastPc     <= '0;
        end else if (instDone_i) begin
            seenDone   <= 1'b1;
            lastBranch <= isBranch;
            lastPc     <= pc_i;
        end
    end

    resetState: assert property (@(posedge CLK)
        rst_i |=> (pc_i == `PC_RESET) && (flags_i == 4'b0000) && !memWe_i && !instDone_i)
        else begin
            assertFails++;
            $error("Outputs not at reset values after reset");
        end

    storePulse: assert property (@(posedge CLK) disable iff (rst_i)
        memWe_i |-> instDone_i ##1 !memWe_i)
        else begin
            assertFails++;
            $error("memWe_o not a single cycle within execute");
        end

    pcSequential: assert property (@(posedge CLK) disable iff (rst_i)
        instDone_i && seenDone && !lastBranch |-> pc_i == lastPc + 8'd2)
        else begin
            assertFails++;
            $error("pc_o did not advance by two bytes");
        end

    branchTaken: assert property (@(posedge CLK) disable iff (rst_i)
        instDone_i && ((op == 4'd0) || ((op == 4'd15) && !flags_i[3]))
        |=> pc_i == $past(ir_i[`DATA_W-1:0]))
        else begin
            assertFails++;
            $error("Taken branch did not load its target");
        end

    branchNotTaken: assert property (@(posedge CLK) disable iff (rst_i)
        instDone_i && (op == 4'd15) && flags_i[3] |=> pc_i == $past(pc_i))
        else begin
            assertFails++;
            $error("BNE with Z set changed pc_o");
        end

endmodule

bind cpuTop cpuProperties props (
    .CLK(CLK), .rst_i(rst_i), .pc_i(pc_o), .flags_i(flags_o),
    .memWe_i(memWe_o), .instDone_i(instDone_o), .ir_i(ir)
);

// File: testbench/cpuTb.sv
// CPU program testbench
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module cpuTb;

    localparam int MAX_STEPS  = 64;
    localparam int WAIT_LIMIT = 20;

    logic                CLK;
    logic                rst;
    logic                loadEn;
    logic [`ADDR_W-1:0]  loadAddr;
    logic [`DATA_W-1:0]  loadData;
    logic                run;
    logic [`ADDR_W-1:0]  pc;
    logic [3:0]          flags;
    logic                memWe;
    logic [`ADDR_W-1:0]  memAddr;
    logic [`DATA_W-1:0]  memData;
    logic                instDone;

    logic [`DATA_W-1:0]  prog [`MEM_DEPTH];
    logic [`DATA_W-1:0]  model [4];      // Expected register contents
    bit                  stepStore [MAX_STEPS];
    logic [`ADDR_W-1:0]  stepAddr [MAX_STEPS];
    logic [`DATA_W-1:0]  stepData [MAX_STEPS];
    logic [3:0]          stepMask [MAX_STEPS];
    logic [3:0]          stepFlags [MAX_STEPS];
    logic [`DATA_W-1:0]  srcByte;
    int                  progLen;
    int                  nSteps;
    int                  errors;
    int                  timeouts;
    integer              seed;

    clockGen clkGen (.CLK(CLK), .rst_o(rst));

    cpuTop dut (
        .CLK(CLK), .rst_i(rst), .loadEn_i(loadEn), .loadAddr_i(loadAddr),
        .loadData_i(loadData), .run_i(run), .pc_o(pc), .flags_o(flags),
        .memWe_o(memWe), .memAddr_o(memAddr), .memData_o(memData), .instDone_o(instDone)
    );

    task automatic putInst(input logic [3:0] op, input logic [3:0] mode, input logic [7:0] lo);
        prog[progLen]     = {op, mode};   // High byte first
        prog[progLen + 1] = lo;
        progLen += 2;
    endtask

    // One entry per executed instruction
    task automatic addStep(input bit isStore, input logic [7:0] addr, input logic [7:0] data,
                           input logic [3:0] mask, input logic [3:0] flagVal);
        stepStore[nSteps] = isStore;
        stepAddr[nSteps]  = addr;
        stepData[nSteps]  = data;
        stepMask[nSteps]  = mask;
        stepFlags[nSteps] = flagVal;
        nSteps++;
    endtask

    task automatic loadImm(input int d, input logic [7:0] imm);
        putInst(cpuPkg::opLd, {2'b01, 2'(d)}, imm);   // Bit 2 selects immediate
        model[d] = imm;
        addStep(1'b0, 8'h00, 8'h00, 4'b0000, 4'b0000);
    endtask

    task automatic loadDirect(input int d, input logic [7:0] addr, input logic [7:0] value);
        putInst(cpuPkg::opLd, {2'b00, 2'(d)}, addr);
        model[d] = value;
        addStep(1'b0, 8'h00, 8'h00, 4'b0000, 4'b0000);
    endtask

    task automatic storeReg(input int s, input logic [7:0] addr);
        putInst(cpuPkg::opSt, {2'b00, 2'(s)}, addr);
        addStep(1'b1, addr, model[s], 4'b0000, 4'b0000);
    endtask

    task automatic aluInst(input cpuPkg::opcodeE op, input int d, input int a, input int b,
                           input logic [3:0] mask, input logic [3:0] flagVal);
        logic [7:0] x;
        logic [7:0] y;
        logic [7:0] res;
        x = model[a];
        y = model[b];
        case (op)
            cpuPkg::opAnd: res = x & y;
            cpuPkg::opOr:  res = x | y;
            cpuPkg::opNot: res = ~x;
            cpuPkg::opAdd: res = x + y;
            cpuPkg::opSub: res = x - y;
            cpuPkg::opLsr: res = x >> 1;
            cpuPkg::opLsl: res = x << 1;
            cpuPkg::opInc: res = x + 8'd1;
            cpuPkg::opDec: res = x - 8'd1;
            default:       res = x;          // MOV
        endcase
        putInst(op, {2'b00, 2'(d)}, {2'b00, 2'(a), 2'b00, 2'(b)});
        model[d] = res;
        addStep(1'b0, 8'h00, 8'h00, mask, flagVal);
    endtask

    // Branch over the next instruction, which is a store that must not run if taken
    task automatic branchSkip(input cpuPkg::opcodeE op);
        putInst(op, 4'b0000, 8'(progLen + 4));
        addStep(1'b0, 8'h00, 8'h00, 4'b0000, 4'b0000);
    endtask

    task automatic buildProgram;
        for (int i = 0; i < 4; i++) begin
            loadImm(i, 8'($random(seed)));
        end
        aluInst(cpuPkg::opAnd, 3, 0, 1, 4'b0000, 4'b0000);
        storeReg(3, 8'h80);
        aluInst(cpuPkg::opOr, 3, 1, 2, 4'b0000, 4'b0000);
        storeReg(3, 8'h81);
        aluInst(cpuPkg::opNot, 3, 2, 0, 4'b0000, 4'b0000);
        storeReg(3, 8'h82);
        aluInst(cpuPkg::opAdd, 3, 0, 1, 4'b0000, 4'b0000);
        storeReg(3, 8'h83);
        aluInst(cpuPkg::opSub, 3, 1, 2, 4'b0000, 4'b0000);
        storeReg(3, 8'h84);
        aluInst(cpuPkg::opLsl, 3, 0, 0, 4'b0000, 4'b0000);
        storeReg(3, 8'h85);
        aluInst(cpuPkg::opLsr, 3, 1, 0, 4'b0000, 4'b0000);
        storeReg(3, 8'h86);
        aluInst(cpuPkg::opMov, 2, 0, 0, 4'b0000, 4'b0000);
        storeReg(2, 8'h87);
        aluInst(cpuPkg::opInc, 1, 2, 0, 4'b0000, 4'b0000);
        storeReg(1, 8'h88);
        aluInst(cpuPkg::opDec, 0, 1, 0, 4'b0000, 4'b0000);
        storeReg(0, 8'h89);
        loadDirect(2, 8'hF0, srcByte);                       // Round trip through memory
        storeReg(2, 8'h8A);
        aluInst(cpuPkg::opSub, 3, 1, 1, 4'b1000, 4'b1000);   // Equal operands set Z
        branchSkip(cpuPkg::opBne);                           // Not taken
        storeReg(3, 8'h8B);
        loadImm(0, 8'h80);
        loadImm(1, 8'h81);
        aluInst(cpuPkg::opAdd, 3, 0, 1, 4'b1100, 4'b0100);   // Carry out, nonzero
        branchSkip(cpuPkg::opBne);
        putInst(cpuPkg::opSt, 4'b0011, 8'hC0);
        storeReg(3, 8'h8C);
        branchSkip(cpuPkg::opBra);
        putInst(cpuPkg::opSt, 4'b0011, 8'hC1);
        storeReg(0, 8'h8D);
        putInst(cpuPkg::opBra, 4'b0000, 8'(progLen));        // Park on itself
    endtask

    task automatic loadMemory;
        for (int i = 0; i < progLen; i++) begin
            @(posedge CLK);
            loadEn   <= 1'b1;
            loadAddr <= 8'(i);
            loadData <= prog[i];
        end
        @(posedge CLK);
        loadAddr <= 8'hF0;
        loadData <= srcByte;
        @(posedge CLK);
        loadEn <= 1'b0;
        run    <= 1'b1;
    endtask

    task automatic waitReset(output bit ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < WAIT_LIMIT) begin
            @(negedge CLK);
            ok = !rst;
            n++;
        end
    endtask

    task automatic waitDone(output bit ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < WAIT_LIMIT) begin
            @(negedge CLK);
            ok = instDone;
            n++;
        end
    endtask

    task automatic checkStep(input int k);
        if (stepStore[k]) begin
            assert (memWe === 1'b1) else begin
                errors++;
                $display("Mismatch memWe_o step %0d: got %h expected 1", k, memWe);
            end
            assert (memAddr === stepAddr[k]) else begin
                errors++;
                $display("Mismatch memAddr_o step %0d: got %h expected %h",
                         k, memAddr, stepAddr[k]);
            end
            assert (memData === stepData[k]) else begin
                errors++;
                $display("Mismatch memData_o step %0d: got %h expected %h",
                         k, memData, stepData[k]);
            end
        end else begin
            assert (memWe === 1'b0) else begin
                errors++;
                $display("Mismatch memWe_o step %0d: got %h expected 0", k, memWe);
            end
        end
        if (stepMask[k] != 4'b0000) begin
            @(negedge CLK);                                  // Flags valid after execute
            assert ((flags & stepMask[k]) === stepFlags[k]) else begin
                errors++;
                $display("Mismatch flags_o step %0d: got %h expected %h under mask %h",
                         k, flags, stepFlags[k], stepMask[k]);
            end
        end
    endtask

    initial begin
        bit ok;
        int k;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        run      = 1'b0;
        errors   = 0;
        timeouts = 0;
        progLen  = 0;
        nSteps   = 0;
        seed     = 32'hfae1;
        srcByte  = 8'($random(seed));
        buildProgram();
        waitReset(ok);
        if (!ok) begin
            timeouts++;
            $display("Timeout: reset was never released");
        end else begin
            loadMemory();
            k = 0;
            while (k < nSteps && timeouts == 0) begin
                waitDone(ok);
                if (!ok) begin
                    timeouts++;
                    $display("Timeout: no instDone_o pulse for step %0d", k);
                end else begin
                    checkStep(k);
                    k++;
                end
            end
            @(posedge CLK);
            run <= 1'b0;
            @(negedge CLK);
        end
        $display("Errors: %0d check, %0d assertion, %0d timeout",
                 errors, dut.props.assertFails, timeouts);
        if (errors == 0 && timeouts == 0 && dut.props.assertFails == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+design
design/cpuPkg.sv
design/alu.sv
design/regFile.sv
design/addressRegs.sv
design/memory.sv
design/controlFsm.sv
design/cpuTop.sv
testbench/clockGen.sv
testbench/cpu_properties.sv
testbench/cpuTb.sv
